// File: src/radio_ctl_cfg.svh
/*
 * Radio control configuration
 * Bus widths and the fixed register map of the GPIO words
 */

`ifndef RADIO_CTL_CFG_SVH
`define RADIO_CTL_CFG_SVH

// **************************************************
// Bus widths
// **************************************************
`define RC_ADDR_W 12
`define RC_DATA_W 32
`define RC_STRB_W 4
`define RC_GPIO_W 96

// **************************************************
// Register map
// **************************************************
// Output words at 0x00, 0x04, 0x08
`define RC_OUT_BASE 12'h000
// Input words at 0x10, 0x14, 0x18
`define RC_IN_BASE 12'h010
`define RC_WORDS 3
// Output bit that drives multi-chip sync
`define RC_SYNC_BIT 51

`endif

// File: src/axil_pkg.sv
/*
 * AXI4-Lite bus types
 * Address, data, strobe and response types plus the channel FSM states
 */

`default_nettype none

`include "radio_ctl_cfg.svh"

package axil_pkg;

  typedef logic [`RC_ADDR_W-1:0] axil_addr_t;
  typedef logic [`RC_DATA_W-1:0] axil_data_t;
  typedef logic [`RC_STRB_W-1:0] axil_strb_t;
  typedef logic [1:0]            axil_resp_t;

  // Response codes
  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  // Write channel FSM with the response pending in WR_RESP
  typedef enum logic {
    WR_IDLE,
    WR_RESP
  } axil_wr_state_e;

  // Read channel FSM with the data pending in RD_DATA
  typedef enum logic {
    RD_IDLE,
    RD_DATA
  } axil_rd_state_e;

endpackage

`default_nettype wire

// File: src/radio_gpio_pkg.sv
/*
 * Radio GPIO field types
 * Field widths of the transceiver, synthesizer and board pins
 */

`default_nettype none

`include "radio_ctl_cfg.svh"

package radio_gpio_pkg;

  // Full GPIO vector of three bus words
  typedef logic [`RC_GPIO_W-1:0] gpio_vec_t;

  // Board pins
  typedef logic [12:0] bd_in_t;
  typedef logic [7:0]  bd_out_t;

  // AD9361 status byte and control nibble
  typedef logic [7:0]  trx_status_t;
  typedef logic [3:0]  trx_ctl_t;

endpackage

`default_nettype wire

// File: src/axil_reg_port.sv
/*
 * AXI4-Lite register port
 * Turns single write and read transfers into one-cycle register strobes
 * and holds the responses until the master accepts them
 */

`default_nettype none

module axil_reg_port (
  input  wire                   ref_clk,
  input  wire                   s_axi_aresetn,

  input  wire                   s_axi_awvalid_i,
  input  axil_pkg::axil_addr_t  s_axi_awaddr_i,
  output logic                  s_axi_awready_o,
  input  wire                   s_axi_wvalid_i,
  input  axil_pkg::axil_data_t  s_axi_wdata_i,
  input  axil_pkg::axil_strb_t  s_axi_wstrb_i,
  output logic                  s_axi_wready_o,
  output logic                  s_axi_bvalid_o,
  output axil_pkg::axil_resp_t  s_axi_bresp_o,
  input  wire                   s_axi_bready_i,
  input  wire                   s_axi_arvalid_i,
  input  axil_pkg::axil_addr_t  s_axi_araddr_i,
  output logic                  s_axi_arready_o,
  output logic                  s_axi_rvalid_o,
  output axil_pkg::axil_data_t  s_axi_rdata_o,
  output axil_pkg::axil_resp_t  s_axi_rresp_o,
  input  wire                   s_axi_rready_i,

  output logic                  reg_wr_o,
  output axil_pkg::axil_addr_t  reg_waddr_o,
  output axil_pkg::axil_data_t  reg_wdata_o,
  output axil_pkg::axil_strb_t  reg_wstrb_o,
  input  wire                   reg_werr_i,
  output logic                  reg_rd_o,
  output axil_pkg::axil_addr_t  reg_raddr_o,
  input  axil_pkg::axil_data_t  reg_rdata_i,
  input  wire                   reg_rerr_i
);

  axil_pkg::axil_wr_state_e wr_state;
  axil_pkg::axil_rd_state_e rd_state;
  logic                     aw_w_ready;
  logic                     ar_ready;
  logic                     wr_hs;
  logic                     rd_hs;
  axil_pkg::axil_resp_t     bresp_q;
  axil_pkg::axil_resp_t     rresp_q;
  axil_pkg::axil_data_t     rdata_q;

  // Address and data are taken together in one beat
  assign wr_hs = aw_w_ready & s_axi_awvalid_i & s_axi_wvalid_i;
  assign rd_hs = ar_ready & s_axi_arvalid_i;

  // **************************************************
  // Write channel
  // **************************************************
  always_ff @(posedge ref_clk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      wr_state   <= axil_pkg::WR_IDLE;
      aw_w_ready <= 1'b0;
    end else begin
      case (wr_state)
        axil_pkg::WR_IDLE: begin
          if (wr_hs) begin
            aw_w_ready <= 1'b0;
            wr_state   <= axil_pkg::WR_RESP;
          end else begin
            aw_w_ready <= s_axi_awvalid_i & s_axi_wvalid_i;
          end
        end
        axil_pkg::WR_RESP: begin
          // Hold until the master takes the response
          if (s_axi_bready_i) begin
            wr_state <= axil_pkg::WR_IDLE;
          end
        end
        default: wr_state <= axil_pkg::WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge ref_clk) begin
    if (wr_hs) begin
      bresp_q <= reg_werr_i ? axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;
    end
  end

  // **************************************************
  // Read channel
  // **************************************************
  always_ff @(posedge ref_clk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      rd_state <= axil_pkg::RD_IDLE;
      ar_ready <= 1'b0;
    end else begin
      case (rd_state)
        axil_pkg::RD_IDLE: begin
          if (rd_hs) begin
            ar_ready <= 1'b0;
            rd_state <= axil_pkg::RD_DATA;
          end else begin
            ar_ready <= s_axi_arvalid_i;
          end
        end
        axil_pkg::RD_DATA: begin
          if (s_axi_rready_i) begin
            rd_state <= axil_pkg::RD_IDLE;
          end
        end
        default: rd_state <= axil_pkg::RD_IDLE;
      endcase
    end
  end

  // Bank answers in the handshake cycle
  always_ff @(posedge ref_clk) begin
    if (rd_hs) begin
      rdata_q <= reg_rdata_i;
      rresp_q <= reg_rerr_i ? axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;
    end
  end

  // Bank side strobes
  assign reg_wr_o    = wr_hs;
  assign reg_waddr_o = s_axi_awaddr_i;
  assign reg_wdata_o = s_axi_wdata_i;
  assign reg_wstrb_o = s_axi_wstrb_i;
  assign reg_rd_o    = rd_hs;
  assign reg_raddr_o = s_axi_araddr_i;

  // Bus outputs
  assign s_axi_awready_o = aw_w_ready;
  assign s_axi_wready_o  = aw_w_ready;
  assign s_axi_bvalid_o  = (wr_state == axil_pkg::WR_RESP);
  assign s_axi_bresp_o   = bresp_q;
  assign s_axi_arready_o = ar_ready;
  assign s_axi_rvalid_o  = (rd_state == axil_pkg::RD_DATA);
  assign s_axi_rdata_o   = rdata_q;
  assign s_axi_rresp_o   = rresp_q;

  // Responses stay put under back-pressure
  a_bresp_hold: assert property (@(posedge ref_clk) disable iff (!s_axi_aresetn)
    s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o && $stable(s_axi_bresp_o));

  a_rdata_hold: assert property (@(posedge ref_clk) disable iff (!s_axi_aresetn)
    s_axi_rvalid_o && !s_axi_rready_i |=>
      s_axi_rvalid_o && $stable(s_axi_rdata_o) && $stable(s_axi_rresp_o));

endmodule

`default_nettype wire

// File: src/gpio_reg_bank.sv
/*
 * GPIO register bank
 * Three byte-writable output words, offset decode and read data select
 */

`default_nettype none

`include "radio_ctl_cfg.svh"

module gpio_reg_bank (
  input  wire                       ref_clk,
  input  wire                       s_axi_aresetn,

  input  wire                       reg_wr_i,
  input  axil_pkg::axil_addr_t      reg_waddr_i,
  input  axil_pkg::axil_data_t      reg_wdata_i,
  input  axil_pkg::axil_strb_t      reg_wstrb_i,
  output logic                      reg_werr_o,
  input  wire                       reg_rd_i,
  input  axil_pkg::axil_addr_t      reg_raddr_i,
  output axil_pkg::axil_data_t      reg_rdata_o,
  output logic                      reg_rerr_o,

  output radio_gpio_pkg::gpio_vec_t gpio_out_o,
  input  radio_gpio_pkg::gpio_vec_t gpio_in_i
);

  axil_pkg::axil_data_t    out_word [`RC_WORDS];
  logic [`RC_WORDS-1:0]    wr_hit;

  // **************************************************
  // Write decode
  // **************************************************
  always_comb begin
    for (int i = 0; i < `RC_WORDS; i++) begin
      wr_hit[i] = (reg_waddr_i == axil_pkg::axil_addr_t'(`RC_OUT_BASE + 4 * i));
    end
  end

  // Only output words are writable
  assign reg_werr_o = ~|wr_hit;

  always_ff @(posedge ref_clk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      for (int i = 0; i < `RC_WORDS; i++) begin
        out_word[i] <= '0;
      end
    end else if (reg_wr_i) begin
      for (int i = 0; i < `RC_WORDS; i++) begin
        for (int b = 0; b < `RC_STRB_W; b++) begin
          if (wr_hit[i] && reg_wstrb_i[b]) begin
            out_word[i][8*b +: 8] <= reg_wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  // **************************************************
  // Read select
  // **************************************************
  always_comb begin
    reg_rdata_o = '0;
    reg_rerr_o  = reg_rd_i;
    for (int i = 0; i < `RC_WORDS; i++) begin
      if (reg_raddr_i == axil_pkg::axil_addr_t'(`RC_OUT_BASE + 4 * i)) begin
        reg_rdata_o = out_word[i];
        reg_rerr_o  = 1'b0;
      end
      if (reg_raddr_i == axil_pkg::axil_addr_t'(`RC_IN_BASE + 4 * i)) begin
        reg_rdata_o = gpio_in_i[`RC_DATA_W*i +: `RC_DATA_W];
        reg_rerr_o  = 1'b0;
      end
    end
    // Idle bus reads as zero
    if (!reg_rd_i) begin
      reg_rdata_o = '0;
    end
  end

  // Word 0 in the low bits
  assign gpio_out_o = {out_word[2], out_word[1], out_word[0]};

  // The port never issues back-to-back writes
  a_wr_single: assert property (@(posedge ref_clk) disable iff (!s_axi_aresetn)
    reg_wr_i |=> !reg_wr_i);

endmodule

`default_nettype wire

// File: src/radio_pin_map.sv
/*
 * Radio pin map
 * Drives the AD9361, AD5355 and board pins from the GPIO vector,
 * synchronizes the status inputs and makes the multi-chip sync pulse
 */

`default_nettype none

`include "radio_ctl_cfg.svh"

module radio_pin_map (
  input  wire                         ref_clk,
  input  wire                         s_axi_aresetn,

  input  radio_gpio_pkg::gpio_vec_t   gpio_out_i,
  output radio_gpio_pkg::gpio_vec_t   gpio_in_o,

  input  radio_gpio_pkg::bd_in_t      gpio_bd_i,
  output radio_gpio_pkg::bd_out_t     gpio_bd_o,
  input  radio_gpio_pkg::trx_status_t gpio_status_0_i,
  input  radio_gpio_pkg::trx_status_t gpio_status_1_i,
  input  wire                         gpio_ad5355_lock_i,
  output radio_gpio_pkg::trx_ctl_t    gpio_ctl_0_o,
  output radio_gpio_pkg::trx_ctl_t    gpio_ctl_1_o,
  output logic                        gpio_debug_1_0_o,
  output logic                        gpio_debug_2_0_o,
  output logic                        gpio_resetb_0_o,
  output logic                        gpio_en_agc_0_o,
  output logic                        enable_0_o,
  output logic                        txnrx_0_o,
  output logic                        gpio_en_agc_1_o,
  output logic                        enable_1_o,
  output logic                        txnrx_1_o,
  output logic                        gpio_calsw_1_0_o,
  output logic                        gpio_calsw_2_0_o,
  output logic                        gpio_calsw_3_1_o,
  output logic                        gpio_calsw_4_1_o,
  output logic                        gpio_ad5355_rfen_o,
  output logic                        gpio_resetb_1_o,
  output logic                        mcs_sync_o
);

  radio_gpio_pkg::bd_in_t      bd_meta, bd_sync;
  radio_gpio_pkg::trx_status_t st0_meta, st0_sync;
  radio_gpio_pkg::trx_status_t st1_meta, st1_sync;
  logic                        lock_meta, lock_sync;
  logic [2:0]                  mcs_sync_m;

  // **************************************************
  // Input synchronizers and multi-chip sync
  // **************************************************
  always_ff @(posedge ref_clk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      bd_meta    <= '0;
      bd_sync    <= '0;
      st0_meta   <= '0;
      st0_sync   <= '0;
      st1_meta   <= '0;
      st1_sync   <= '0;
      lock_meta  <= 1'b0;
      lock_sync  <= 1'b0;
      mcs_sync_m <= '0;
      mcs_sync_o <= 1'b0;
    end else begin
      bd_meta    <= gpio_bd_i;
      bd_sync    <= bd_meta;
      st0_meta   <= gpio_status_0_i;
      st0_sync   <= st0_meta;
      st1_meta   <= gpio_status_1_i;
      st1_sync   <= st1_meta;
      lock_meta  <= gpio_ad5355_lock_i;
      lock_sync  <= lock_meta;
      mcs_sync_m <= {mcs_sync_m[1:0], gpio_out_i[`RC_SYNC_BIT]};
      // Pulse on the falling edge only
      mcs_sync_o <= mcs_sync_m[2] & ~mcs_sync_m[1];
    end
  end

  // Input words with loopback where no pin is read
  assign gpio_in_o[12:0]  = bd_sync;
  assign gpio_in_o[21:13] = gpio_out_i[21:13];
  assign gpio_in_o[29:22] = st0_sync;
  assign gpio_in_o[37:30] = st1_sync;
  assign gpio_in_o[63:38] = gpio_out_i[63:38];
  assign gpio_in_o[64]    = lock_sync;
  assign gpio_in_o[95:65] = gpio_out_i[95:65];

  // **************************************************
  // Output pins
  // **************************************************
  assign gpio_bd_o          = gpio_out_i[20:13];
  assign gpio_ctl_0_o       = gpio_out_i[41:38];
  assign gpio_ctl_1_o       = gpio_out_i[45:42];
  assign gpio_debug_1_0_o   = gpio_out_i[46];
  assign gpio_debug_2_0_o   = gpio_out_i[47];
  assign gpio_resetb_0_o    = gpio_out_i[52];
  assign gpio_en_agc_0_o    = gpio_out_i[53];
  // Enable and txnrx straight from GPIO without the LVDS core
  assign enable_0_o         = gpio_out_i[54];
  assign txnrx_0_o          = gpio_out_i[55];
  assign gpio_en_agc_1_o    = gpio_out_i[56];
  assign enable_1_o         = gpio_out_i[57];
  assign txnrx_1_o          = gpio_out_i[58];
  assign gpio_calsw_1_0_o   = gpio_out_i[59];
  assign gpio_calsw_2_0_o   = gpio_out_i[60];
  assign gpio_calsw_3_1_o   = gpio_out_i[61];
  assign gpio_calsw_4_1_o   = gpio_out_i[62];
  assign gpio_ad5355_rfen_o = gpio_out_i[63];
  assign gpio_resetb_1_o    = gpio_out_i[65];

  a_mcs_single: assert property (@(posedge ref_clk) disable iff (!s_axi_aresetn)
    mcs_sync_o |=> !mcs_sync_o);

endmodule

`default_nettype wire

// File: src/radio_ctl_top.sv
/*
 * Radio control top
 * AXI4-Lite GPIO path to the AD9361, AD5355 and board pins
 */

`default_nettype none

module radio_ctl_top (
  input  wire                         ref_clk,
  input  wire                         s_axi_aresetn,

  input  wire                         s_axi_awvalid_i,
  input  axil_pkg::axil_addr_t        s_axi_awaddr_i,
  output logic                        s_axi_awready_o,
  input  wire                         s_axi_wvalid_i,
  input  axil_pkg::axil_data_t        s_axi_wdata_i,
  input  axil_pkg::axil_strb_t        s_axi_wstrb_i,
  output logic                        s_axi_wready_o,
  output logic                        s_axi_bvalid_o,
  output axil_pkg::axil_resp_t        s_axi_bresp_o,
  input  wire                         s_axi_bready_i,
  input  wire                         s_axi_arvalid_i,
  input  axil_pkg::axil_addr_t        s_axi_araddr_i,
  output logic                        s_axi_arready_o,
  output logic                        s_axi_rvalid_o,
  output axil_pkg::axil_data_t        s_axi_rdata_o,
  output axil_pkg::axil_resp_t        s_axi_rresp_o,
  input  wire                         s_axi_rready_i,

  input  radio_gpio_pkg::bd_in_t      gpio_bd_i,
  output radio_gpio_pkg::bd_out_t     gpio_bd_o,
  input  radio_gpio_pkg::trx_status_t gpio_status_0_i,
  input  radio_gpio_pkg::trx_status_t gpio_status_1_i,
  input  wire                         gpio_ad5355_lock_i,
  output radio_gpio_pkg::trx_ctl_t    gpio_ctl_0_o,
  output radio_gpio_pkg::trx_ctl_t    gpio_ctl_1_o,
  output logic                        gpio_debug_1_0_o,
  output logic                        gpio_debug_2_0_o,
  output logic                        gpio_resetb_0_o,
  output logic                        gpio_en_agc_0_o,
  output logic                        enable_0_o,
  output logic                        txnrx_0_o,
  output logic                        gpio_en_agc_1_o,
  output logic                        enable_1_o,
  output logic                        txnrx_1_o,
  output logic                        gpio_calsw_1_0_o,
  output logic                        gpio_calsw_2_0_o,
  output logic                        gpio_calsw_3_1_o,
  output logic                        gpio_calsw_4_1_o,
  output logic                        gpio_ad5355_rfen_o,
  output logic                        gpio_resetb_1_o,
  output logic                        mcs_sync_o
);

  logic                      reg_wr;
  axil_pkg::axil_addr_t      reg_waddr;
  axil_pkg::axil_data_t      reg_wdata;
  axil_pkg::axil_strb_t      reg_wstrb;
  logic                      reg_werr;
  logic                      reg_rd;
  axil_pkg::axil_addr_t      reg_raddr;
  axil_pkg::axil_data_t      reg_rdata;
  logic                      reg_rerr;
  radio_gpio_pkg::gpio_vec_t gpio_out;
  radio_gpio_pkg::gpio_vec_t gpio_in;

  // Bus side ports match by name
  axil_reg_port u_axil_reg_port (
    .*,
    .reg_wr_o    (reg_wr),
    .reg_waddr_o (reg_waddr),
    .reg_wdata_o (reg_wdata),
    .reg_wstrb_o (reg_wstrb),
    .reg_werr_i  (reg_werr),
    .reg_rd_o    (reg_rd),
    .reg_raddr_o (reg_raddr),
    .reg_rdata_i (reg_rdata),
    .reg_rerr_i  (reg_rerr)
  );

  gpio_reg_bank u_gpio_reg_bank (
    .ref_clk       (ref_clk),
    .s_axi_aresetn (s_axi_aresetn),
    .reg_wr_i      (reg_wr),
    .reg_waddr_i   (reg_waddr),
    .reg_wdata_i   (reg_wdata),
    .reg_wstrb_i   (reg_wstrb),
    .reg_werr_o    (reg_werr),
    .reg_rd_i      (reg_rd),
    .reg_raddr_i   (reg_raddr),
    .reg_rdata_o   (reg_rdata),
    .reg_rerr_o    (reg_rerr),
    .gpio_out_o    (gpio_out),
    .gpio_in_i     (gpio_in)
  );

  // Pins match by name
  radio_pin_map u_radio_pin_map (
    .*,
    .gpio_out_i (gpio_out),
    .gpio_in_o  (gpio_in)
  );

endmodule

`default_nettype wire

// File: verif/tb_radio_ctl.sv
/*
 * Radio control testbench
 * Drives radio_ctl_top over AXI4-Lite and checks words, pins and sync pulse
 */

`default_nettype none

`include "radio_ctl_cfg.svh"

module tb_radio_ctl;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [1:0] OKAY = 2'b00;
  localparam logic [1:0] SLVERR = 2'b10;
  // Several times the cycles the whole sequence needs
  localparam int TIMEOUT_CYCLES = 20000;

  logic ref_clk, s_axi_aresetn;
  logic s_axi_awvalid_i, s_axi_awready_o, s_axi_wvalid_i, s_axi_wready_o;
  logic [11:0] s_axi_awaddr_i, s_axi_araddr_i;
  logic [31:0] s_axi_wdata_i, s_axi_rdata_o;
  logic [3:0] s_axi_wstrb_i;
  logic s_axi_bvalid_o, s_axi_bready_i, s_axi_arvalid_i, s_axi_arready_o;
  logic s_axi_rvalid_o, s_axi_rready_i;
  logic [1:0] s_axi_bresp_o, s_axi_rresp_o;
  logic [12:0] gpio_bd_i;
  logic [7:0] gpio_bd_o, gpio_status_0_i, gpio_status_1_i;
  logic gpio_ad5355_lock_i;
  logic [3:0] gpio_ctl_0_o, gpio_ctl_1_o;
  logic gpio_debug_1_0_o, gpio_debug_2_0_o, gpio_resetb_0_o, gpio_en_agc_0_o;
  logic enable_0_o, txnrx_0_o, gpio_en_agc_1_o, enable_1_o, txnrx_1_o;
  logic gpio_calsw_1_0_o, gpio_calsw_2_0_o, gpio_calsw_3_1_o, gpio_calsw_4_1_o;
  logic gpio_ad5355_rfen_o, gpio_resetb_1_o, mcs_sync_o;

  logic [95:0] model_out;
  logic [31:0] rng;
  int          cycles;
  int          wr_done_cycle;
  int          mcs_count;
  int          mcs_cycle;

  radio_ctl_top UUT (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Input vector from the pins where read and the output bits elsewhere
  function automatic logic [95:0] expected_inputs(input logic [95:0] outv,
      input logic [12:0] bd, input logic [7:0] s0, input logic [7:0] s1, input logic lock);
    logic [95:0] v;
    v = outv;
    v[12:0] = bd;
    v[29:22] = s0;
    v[37:30] = s1;
    v[64] = lock;
    return v;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [95:0] exp, input logic [95:0] act);
    assert (act === exp) else
      abort_run($sformatf("MISMATCH at %0d ns: %s expected %h, got %h",
                          $time, name, exp, act));
  endtask

  task automatic check_pins();
    check_value("gpio_bd_o", 96'(model_out[20:13]), 96'(gpio_bd_o));
    check_value("gpio_ctl_0_o", 96'(model_out[41:38]), 96'(gpio_ctl_0_o));
    check_value("gpio_ctl_1_o", 96'(model_out[45:42]), 96'(gpio_ctl_1_o));
    // Bits 65, 63 down to 52, 47 and 46 in pin order
    check_value("single-bit pins",
                96'({model_out[65], model_out[63:52], model_out[47:46]}),
                96'({gpio_resetb_1_o, gpio_ad5355_rfen_o, gpio_calsw_4_1_o,
                     gpio_calsw_3_1_o, gpio_calsw_2_0_o, gpio_calsw_1_0_o, txnrx_1_o,
                     enable_1_o, gpio_en_agc_1_o, txnrx_0_o, enable_0_o, gpio_en_agc_0_o,
                     gpio_resetb_0_o, gpio_debug_2_0_o, gpio_debug_1_0_o}));
  endtask

  // **************************************************
  // Bus tasks entered on a falling edge
  // **************************************************
  task automatic bus_write(input logic [11:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [1:0] exp_resp;
    int         stall;
    exp_resp = SLVERR;
    for (int k = 0; k < 3; k++) begin
      if (addr == 12'(`RC_OUT_BASE + 4 * k)) begin
        exp_resp = OKAY;
        for (int b = 0; b < 4; b++) begin
          if (strb[b]) model_out[32*k + 8*b +: 8] = data[8*b +: 8];
        end
      end
    end
    s_axi_awaddr_i = addr;
    s_axi_wdata_i = data;
    s_axi_wstrb_i = strb;
    s_axi_awvalid_i = 1'b1;
    s_axi_wvalid_i = 1'b1;
    while (!(s_axi_awready_o && s_axi_wready_o)) @(negedge ref_clk);
    @(negedge ref_clk);
    s_axi_awvalid_i = 1'b0;
    s_axi_wvalid_i = 1'b0;
    wr_done_cycle = cycles;
    check_value("s_axi_bvalid_o", 96'(1'b1), 96'(s_axi_bvalid_o));
    check_value("s_axi_bresp_o", 96'(exp_resp), 96'(s_axi_bresp_o));
    check_pins();
    rng = xorshift(rng);
    stall = int'(rng % 32'd6);
    repeat (stall) begin
      @(negedge ref_clk);
      check_value("s_axi_bvalid_o", 96'(1'b1), 96'(s_axi_bvalid_o));
      check_value("s_axi_bresp_o", 96'(exp_resp), 96'(s_axi_bresp_o));
    end
    s_axi_bready_i = 1'b1;
    @(negedge ref_clk);
    s_axi_bready_i = 1'b0;
    check_value("s_axi_bvalid_o", 96'(1'b0), 96'(s_axi_bvalid_o));
  endtask

  task automatic bus_read(input logic [11:0] addr);
    logic [95:0] exp_in;
    logic [31:0] exp_data;
    logic [1:0]  exp_resp;
    int          stall;
    exp_in = expected_inputs(model_out, gpio_bd_i, gpio_status_0_i, gpio_status_1_i,
                             gpio_ad5355_lock_i);
    exp_data = '0;
    exp_resp = SLVERR;
    for (int k = 0; k < 3; k++) begin
      if (addr == 12'(`RC_OUT_BASE + 4 * k)) begin
        exp_data = model_out[32*k +: 32];
        exp_resp = OKAY;
      end
      if (addr == 12'(`RC_IN_BASE + 4 * k)) begin
        exp_data = exp_in[32*k +: 32];
        exp_resp = OKAY;
      end
    end
    s_axi_araddr_i = addr;
    s_axi_arvalid_i = 1'b1;
    while (!s_axi_arready_o) @(negedge ref_clk);
    @(negedge ref_clk);
    s_axi_arvalid_i = 1'b0;
    rng = xorshift(rng);
    stall = int'(rng % 32'd6);
    // Data one cycle after the address handshake and held until accepted
    for (int n = 0; n <= stall; n++) begin
      if (n > 0) @(negedge ref_clk);
      check_value("s_axi_rvalid_o", 96'(1'b1), 96'(s_axi_rvalid_o));
      check_value("s_axi_rdata_o", 96'(exp_data), 96'(s_axi_rdata_o));
      check_value("s_axi_rresp_o", 96'(exp_resp), 96'(s_axi_rresp_o));
    end
    s_axi_rready_i = 1'b1;
    @(negedge ref_clk);
    s_axi_rready_i = 1'b0;
    check_value("s_axi_rvalid_o", 96'(1'b0), 96'(s_axi_rvalid_o));
  endtask

  task automatic read_all_words();
    for (int k = 0; k < 3; k++) begin
      bus_read(12'(`RC_OUT_BASE + 4 * k));
      bus_read(12'(`RC_IN_BASE + 4 * k));
    end
  endtask

  // **************************************************
  // Clock, watchdog and protocol checks
  // **************************************************
  initial begin
    ref_clk = 1'b0;
    forever #5 ref_clk = ~ref_clk;
  end

  always @(posedge ref_clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) abort_run("Timeout: the test sequence did not finish");
  end

  always @(negedge ref_clk) begin
    if (mcs_sync_o) begin
      mcs_count = mcs_count + 1;
      mcs_cycle = cycles;
    end
  end

  a_b_hold: assert property (@(posedge ref_clk) disable iff (!s_axi_aresetn)
    s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o && $stable(s_axi_bresp_o))
    else abort_run("Write response dropped or changed while bready was low");
  a_r_hold: assert property (@(posedge ref_clk) disable iff (!s_axi_aresetn)
    s_axi_rvalid_o && !s_axi_rready_i |=>
      s_axi_rvalid_o && $stable(s_axi_rdata_o) && $stable(s_axi_rresp_o))
    else abort_run("Read response dropped or changed while rready was low");
  a_aw_w_pair: assert property (@(posedge ref_clk) s_axi_awready_o == s_axi_wready_o)
    else abort_run("awready and wready differ");
  a_ar_once: assert property (@(posedge ref_clk) disable iff (!s_axi_aresetn)
    s_axi_arready_o && s_axi_arvalid_i |=> !s_axi_arready_o && s_axi_rvalid_o)
    else abort_run("Read address accept not followed by read data");
  a_mcs_once: assert property (@(posedge ref_clk) disable iff (!s_axi_aresetn)
    mcs_sync_o |=> !mcs_sync_o)
    else abort_run("mcs_sync_o stayed high for two cycles");

  // **************************************************
  // Test sequence
  // **************************************************
  initial begin
    logic [31:0] w1;
    int          count0;
    s_axi_aresetn = 1'b0;
    {s_axi_awvalid_i, s_axi_wvalid_i, s_axi_bready_i} = '0;
    {s_axi_arvalid_i, s_axi_rready_i} = '0;
    s_axi_awaddr_i = '0;
    s_axi_araddr_i = '0;
    s_axi_wdata_i = '0;
    s_axi_wstrb_i = '0;
    gpio_bd_i = '0;
    gpio_status_0_i = '0;
    gpio_status_1_i = '0;
    gpio_ad5355_lock_i = 1'b0;
    model_out = '0;
    rng = 32'd53;
    cycles = 0;
    mcs_count = 0;
    mcs_cycle = 0;
    repeat (10) @(negedge ref_clk);
    s_axi_aresetn = 1'b1;
    @(negedge ref_clk);

    // Reset state
    check_pins();
    check_value("reset outputs", 96'(0), 96'({mcs_sync_o, s_axi_bvalid_o, s_axi_rvalid_o,
                s_axi_awready_o, s_axi_wready_o, s_axi_arready_o}));

    // Random strobed writes to the output words
    for (int i = 0; i < 60; i++) begin
      rng = xorshift(rng);
      w1 = rng;
      rng = xorshift(rng);
      bus_write(12'(`RC_OUT_BASE + 4 * int'(rng % 32'd3)), w1, rng[7:4]);
      bus_read(12'(`RC_OUT_BASE + 4 * int'(rng % 32'd3)));
    end
    read_all_words();

    // Random pin inputs read after the synchronizers settle
    for (int i = 0; i < 20; i++) begin
      rng = xorshift(rng);
      gpio_bd_i = rng[12:0];
      gpio_status_0_i = rng[20:13];
      gpio_status_1_i = rng[28:21];
      gpio_ad5355_lock_i = rng[29];
      repeat (3) @(negedge ref_clk);
      read_all_words();
    end

    // Input and unmapped offsets
    bus_write(12'h010, 32'hffff_ffff, 4'hf);
    bus_write(12'h014, 32'hffff_ffff, 4'hf);
    bus_write(12'h018, 32'hffff_ffff, 4'hf);
    bus_write(12'h00c, 32'ha5a5_a5a5, 4'hf);
    bus_write(12'h01c, 32'h5a5a_5a5a, 4'hf);
    bus_write(12'h800, 32'h1234_5678, 4'hf);
    read_all_words();
    bus_read(12'h00c);
    bus_read(12'h01c);
    bus_read(12'h020);
    bus_read(12'hffc);

    // Multi-chip sync on the falling sync bit only
    w1 = model_out[63:32];
    w1[`RC_SYNC_BIT-32] = 1'b0;
    bus_write(12'h004, w1, 4'hf);
    repeat (8) @(negedge ref_clk);
    count0 = mcs_count;
    w1[`RC_SYNC_BIT-32] = 1'b1;
    bus_write(12'h004, w1, 4'hf);
    repeat (8) @(negedge ref_clk);
    check_value("mcs_sync_o pulses after rise", 96'(count0), 96'(mcs_count));
    w1[`RC_SYNC_BIT-32] = 1'b0;
    bus_write(12'h004, w1, 4'hf);
    repeat (8) @(negedge ref_clk);
    check_value("mcs_sync_o pulses after fall", 96'(count0 + 1), 96'(mcs_count));
    if (mcs_cycle - wr_done_cycle > 4 || mcs_cycle < wr_done_cycle)
      abort_run("mcs_sync_o pulse not within four cycles of the sync bit falling");
    read_all_words();

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+src
src/axil_pkg.sv
src/radio_gpio_pkg.sv
src/axil_reg_port.sv
src/gpio_reg_bank.sv
src/radio_pin_map.sv
src/radio_ctl_top.sv
verif/tb_radio_ctl.sv

// File: run_sim.sh
#!/bin/sh
# Build the radio control testbench with Verilator and run it
# Exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_radio_ctl -f list.f -o tb_radio_ctl
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_radio_ctl
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit "$status"
fi

exit 0
